// File: common/blimp_pkg.sv
/*
  Shared types for the reduced Blimp core. Eight architectural registers,
  r0 reads as zero. Sequence numbers are 5 bits and wrap, so they order
  results only within a window of 32 instructions.
*/
`default_nettype none

package blimp_pkg;

  //------------------------------------------------------------
  // Sizes
  //------------------------------------------------------------

  localparam int num_regs       = 8;
  localparam int mul_stages     = 4;
  localparam int mul_slice_bits = 32 / mul_stages;  // Multiplier bits per stage

  typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
  typedef logic [31:0]                 data_t;
  typedef logic [4:0]                  seq_num_t;
  typedef logic [15:0]                 imm_t;

  //------------------------------------------------------------
  // Operations
  //------------------------------------------------------------

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_SLL = 3'd4,  // Shift by low 5 bits of rs2
    OP_LI  = 3'd5,  // Load immediate
    OP_MUL = 3'd6
  } op_t;

  //------------------------------------------------------------
  // Pipe payloads
  //------------------------------------------------------------

  // Decoded instruction from the testbench
  typedef struct packed {
    op_t       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;  // Zero-extended on use
  } inst_t;

  // Issued operation with operands already read
  typedef struct packed {
    op_t       op;
    seq_num_t  seq;
    reg_addr_t rd;
    data_t     opa;
    data_t     opb;  // Immediate for OP_LI
  } issue_t;

  // Completed result headed for the register file
  typedef struct packed {
    seq_num_t  seq;
    reg_addr_t waddr;
    data_t     wdata;
  } result_t;

endpackage

`default_nettype wire

// File: hw/decode_issue/decode_issue_unit.sv
/*
  Register file, scoreboard and single issue register. An instruction
  waits while any register it reads or writes has a result pending.
  No bypass: a value written back is readable the following cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module decode_issue_unit (
  input  logic               clk,
  input  logic               reset,

  input  logic               inst_val,
  input  blimp_pkg::inst_t   inst,
  output logic               inst_rdy,

  output logic               alu_val,
  output blimp_pkg::issue_t  alu_req,
  input  logic               alu_rdy,

  output logic               mul_val,
  output blimp_pkg::issue_t  mul_req,

  input  logic               wb_val,
  input  blimp_pkg::result_t wb
);

  import blimp_pkg::*;

  data_t               rf [num_regs];
  logic [num_regs-1:0] pending;      // One bit per register with a write in flight
  seq_num_t            seq_next;

  logic   iss_val;
  logic   iss_mul;
  issue_t iss;

  logic   uses_srcs;
  logic   hazard;
  logic   iss_free;
  logic   accept;

  //------------------------------------------------------------
  // Register file
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_val && wb.waddr != '0) begin  // r0 stays zero
      rf[wb.waddr] <= wb.wdata;
    end
  end

  //------------------------------------------------------------
  // Scoreboard and hazard check
  //------------------------------------------------------------

  assign uses_srcs = (inst.op != OP_LI);
  assign hazard    = pending[inst.rd] ||
                     (uses_srcs && (pending[inst.rs1] || pending[inst.rs2]));

  // Issue register can take a new entry unless an ALU op is stuck in it
  assign iss_free  = !iss_val || iss_mul || alu_rdy;
  assign inst_rdy  = !hazard && iss_free;
  assign accept    = inst_val && inst_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (wb_val) begin
        pending[wb.waddr] <= 1'b0;
      end
      if (accept && inst.rd != '0) begin
        pending[inst.rd] <= 1'b1;  // Never the same register as the clear
      end
    end
  end

  //------------------------------------------------------------
  // Issue register and sequence numbering
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      iss_val  <= 1'b0;
      seq_next <= '0;
    end else if (accept) begin
      iss_val  <= 1'b1;
      seq_next <= seq_next + 1'b1;
    end else if (iss_free) begin
      iss_val  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss.op  <= inst.op;
      iss.seq <= seq_next;
      iss.rd  <= inst.rd;
      iss.opa <= rf[inst.rs1];
      iss.opb <= (inst.op == OP_LI) ? data_t'(inst.imm) : rf[inst.rs2];
    end
  end

  // Steering by op
  assign iss_mul = (iss.op == OP_MUL);
  assign alu_val = iss_val && !iss_mul;
  assign mul_val = iss_val && iss_mul;
  assign alu_req = iss;
  assign mul_req = iss;

endmodule

`default_nettype wire

// File: hw/execute/alu_unit.sv
/*
  Single-cycle ALU for every op except OP_MUL. The result register
  holds while the downstream ready is low.
*/
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic               clk,
  input  logic               reset,

  input  logic               req_val,
  input  blimp_pkg::issue_t  req,
  output logic               req_rdy,

  output logic               res_val,
  output blimp_pkg::result_t res,
  input  logic               res_rdy
);

  import blimp_pkg::*;

  data_t alu_out;
  logic  req_go;

  always_comb begin
    case (req.op)
      OP_ADD:  alu_out = req.opa + req.opb;
      OP_SUB:  alu_out = req.opa - req.opb;
      OP_AND:  alu_out = req.opa & req.opb;
      OP_XOR:  alu_out = req.opa ^ req.opb;
      OP_SLL:  alu_out = req.opa << req.opb[4:0];
      OP_LI:   alu_out = req.opb;
      default: alu_out = '0;  // Multiplies go to the other pipe
    endcase
  end

  assign req_rdy = !res_val || res_rdy;
  assign req_go  = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_val <= 1'b0;
    end else if (req_go) begin
      res_val <= 1'b1;
    end else if (res_rdy) begin
      res_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      res.seq   <= req.seq;
      res.waddr <= req.rd;
      res.wdata <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: hw/execute/ex_queue.sv
/*
  One-entry result queue. A full entry can be replaced in the cycle it
  drains, so back-to-back results pass without a bubble.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_queue (
  input  logic               clk,
  input  logic               reset,

  input  logic               in_val,
  input  blimp_pkg::result_t in,
  output logic               in_rdy,

  output logic               out_val,
  output blimp_pkg::result_t out,
  input  logic               out_rdy
);

  logic full;
  logic enq;

  assign in_rdy  = !full || out_rdy;  // Drain and refill in one cycle
  assign enq     = in_val && in_rdy;
  assign out_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (enq) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (enq) begin
      out <= in;
    end
  end

endmodule

`default_nettype wire

// File: hw/execute/pipelined_multiplier.sv
/*
  Multiplier pipe of mul_stages registers, low 32 bits of the product.
  Each stage adds one mul_slice_bits slice of opb; needs mul_stages >= 2.
  Never stalls, so writeback must always take its result.
*/
`timescale 1ns/1ps
`default_nettype none

module pipelined_multiplier (
  input  logic               clk,
  input  logic               reset,

  input  logic               req_val,
  input  blimp_pkg::issue_t  req,

  output logic               res_val,
  output blimp_pkg::result_t res
);

  import blimp_pkg::*;

  logic [mul_stages-1:0] stage_val;
  seq_num_t              stage_seq [mul_stages];
  reg_addr_t             stage_rd  [mul_stages];
  data_t                 stage_acc [mul_stages];
  data_t                 stage_a   [mul_stages-1];  // Operands only needed until the last add
  data_t                 stage_b   [mul_stages-1];

  // Partial product of opa with slice s of opb, shifted into place
  function automatic data_t partial(input data_t a, input data_t b, input int s);
    data_t slice;
    slice = data_t'(b[s*mul_slice_bits +: mul_slice_bits]);
    return (a * slice) << (s * mul_slice_bits);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_val <= '0;
    end else begin
      stage_val <= {stage_val[mul_stages-2:0], req_val};
    end
  end

  //------------------------------------------------------------
  // Datapath stages
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    stage_seq[0] <= req.seq;
    stage_rd[0]  <= req.rd;
    stage_acc[0] <= partial(req.opa, req.opb, 0);
    stage_a[0]   <= req.opa;
    stage_b[0]   <= req.opb;

    for (int s = 1; s < mul_stages; s++) begin
      stage_seq[s] <= stage_seq[s-1];
      stage_rd[s]  <= stage_rd[s-1];
      stage_acc[s] <= stage_acc[s-1] + partial(stage_a[s-1], stage_b[s-1], s);
    end

    for (int s = 1; s < mul_stages - 1; s++) begin
      stage_a[s] <= stage_a[s-1];
      stage_b[s] <= stage_b[s-1];
    end
  end

  assign res_val   = stage_val[mul_stages-1];
  assign res.seq   = stage_seq[mul_stages-1];
  assign res.waddr = stage_rd[mul_stages-1];
  assign res.wdata = stage_acc[mul_stages-1];

endmodule

`default_nettype wire

// File: hw/writeback/writeback_unit.sv
/*
  Picks one result per cycle, multiplier first. The write port to the
  register file is combinational; the trace record lags it by a cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
  input  logic               clk,
  input  logic               reset,

  input  logic               mul_val,
  input  blimp_pkg::result_t mul_res,

  input  logic               q_val,
  input  blimp_pkg::result_t q_res,
  output logic               q_rdy,

  output logic               wb_val,
  output blimp_pkg::result_t wb,

  output logic               trace_val,
  output blimp_pkg::result_t trace
);

  //------------------------------------------------------------
  // Arbitration
  //------------------------------------------------------------

  // Multiplier cannot stall, so it always wins
  assign q_rdy  = !mul_val;
  assign wb_val = mul_val || q_val;
  assign wb     = mul_val ? mul_res : q_res;

  //------------------------------------------------------------
  // Trace register
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= wb_val;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_val) begin
      trace <= wb;  // Includes writes to r0
    end
  end

endmodule

`default_nettype wire

// File: hw/blimp_core.sv
/*
  Reduced Blimp core with out-of-order completion. No fetch, memory,
  branches or renaming; the scoreboard keeps results program-correct.
*/
`timescale 1ns/1ps
`default_nettype none

module blimp_core (
  input  logic               clk,
  input  logic               reset,

  input  logic               inst_val,
  input  blimp_pkg::inst_t   inst,
  output logic               inst_rdy,

  output logic               trace_val,
  output blimp_pkg::result_t trace
);

  import blimp_pkg::*;

  //------------------------------------------------------------
  // Links between units
  //------------------------------------------------------------

  logic    alu_val;
  issue_t  alu_req;
  logic    alu_rdy;
  logic    mul_val;
  issue_t  mul_req;

  logic    alu_res_val;  // ALU into queue
  result_t alu_res;
  logic    alu_res_rdy;

  logic    q_val;        // Queue into writeback
  result_t q_res;
  logic    q_rdy;

  logic    mul_res_val;
  result_t mul_res;

  logic    wb_val;
  result_t wb;

  //------------------------------------------------------------
  // Units
  //------------------------------------------------------------

  decode_issue_unit diu (
    .clk      (clk),
    .reset    (reset),
    .inst_val (inst_val),
    .inst     (inst),
    .inst_rdy (inst_rdy),
    .alu_val  (alu_val),
    .alu_req  (alu_req),
    .alu_rdy  (alu_rdy),
    .mul_val  (mul_val),
    .mul_req  (mul_req),
    .wb_val   (wb_val),
    .wb       (wb)
  );

  alu_unit alu_xu (
    .clk     (clk),
    .reset   (reset),
    .req_val (alu_val),
    .req     (alu_req),
    .req_rdy (alu_rdy),
    .res_val (alu_res_val),
    .res     (alu_res),
    .res_rdy (alu_res_rdy)
  );

  ex_queue alu_buf (
    .clk     (clk),
    .reset   (reset),
    .in_val  (alu_res_val),
    .in      (alu_res),
    .in_rdy  (alu_res_rdy),
    .out_val (q_val),
    .out     (q_res),
    .out_rdy (q_rdy)
  );

  pipelined_multiplier mul_xu (
    .clk     (clk),
    .reset   (reset),
    .req_val (mul_val),
    .req     (mul_req),
    .res_val (mul_res_val),
    .res     (mul_res)
  );

  writeback_unit wbu (
    .clk       (clk),
    .reset     (reset),
    .mul_val   (mul_res_val),
    .mul_res   (mul_res),
    .q_val     (q_val),
    .q_res     (q_res),
    .q_rdy     (q_rdy),
    .wb_val    (wb_val),
    .wb        (wb),
    .trace_val (trace_val),
    .trace     (trace)
  );

endmodule

`default_nettype wire

// File: test/blimp_core_assert.sv
/*
  Concurrent checks on core internals. Bound into blimp_core and
  needs a simulator that evaluates concurrent assertions.
*/
`timescale 1ns/1ps
`default_nettype none

module blimp_core_assert (
  input logic               clk,
  input logic               reset,
  input logic               inst_rdy,
  input logic               trace_val,
  input logic               alu_res_val,
  input logic               alu_res_rdy,
  input blimp_pkg::result_t alu_res,
  input logic               mul_res_val,
  input logic               q_val,
  input blimp_pkg::result_t q_res
);

  int fail_count = 0;

  // Idle and ready straight out of reset
  reset_state: assert property (@(posedge clk) reset |=> (!trace_val && inst_rdy))
    else begin
      fail_count++;
      $error("Core not idle and ready after reset");
    end

  // Queue output only appears after an accepted input
  q_fill: assert property (@(posedge clk) disable iff (reset)
      $rose(q_val) |-> $past(alu_res_val && alu_res_rdy))
    else begin
      fail_count++;
      $error("Queue went valid without taking an input");
    end

  // Stalled ALU result is held, not dropped
  alu_hold: assert property (@(posedge clk) disable iff (reset)
      (alu_res_val && !alu_res_rdy) |=> (alu_res_val && $stable(alu_res)))
    else begin
      fail_count++;
      $error("ALU result changed or vanished while stalled");
    end

  // Queue result waits while the multiplier owns the write port
  one_writer: assert property (@(posedge clk) disable iff (reset)
      (mul_res_val && q_val) |=> (q_val && $stable(q_res)))
    else begin
      fail_count++;
      $error("Multiplier and queue results written in the same cycle");
    end

endmodule

bind blimp_core blimp_core_assert blimp_core_assert_inst (
  .clk         (clk),
  .reset       (reset),
  .inst_rdy    (inst_rdy),
  .trace_val   (trace_val),
  .alu_res_val (alu_res_val),
  .alu_res_rdy (alu_res_rdy),
  .alu_res     (alu_res),
  .mul_res_val (mul_res_val),
  .q_val       (q_val),
  .q_res       (q_res)
);

`default_nettype wire

// File: test/blimp_core_tb.sv
/*
  Testbench for blimp_core. Runs a fixed instruction table and checks each
  trace record against an in-order model indexed by seq. The table must stay
  below 32 entries so that seq maps straight onto the table index.
*/
`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb;

  import blimp_pkg::*;

  localparam int tbl_size   = 24;
  localparam int wait_limit = 100;  // Cycles before a wait gives up

  typedef struct {
    inst_t     inst;
    bit        gap_ok;     // LCG may insert an idle cycle before it
    int        overtakes;  // Earlier seq this entry must trace ahead of, or -1
    reg_addr_t exp_waddr;
    data_t     exp_wdata;
  } entry_t;

  logic    clk;
  logic    reset;
  logic    inst_val;
  inst_t   inst;
  logic    inst_rdy;
  logic    trace_val;
  result_t trace;

  entry_t      tbl [tbl_size];
  bit          seen [tbl_size];
  int          n_entries;
  int          trace_count;
  logic [31:0] lcg_state;

  blimp_core blimp_core_inst (
    .clk       (clk),
    .reset     (reset),
    .inst_val  (inst_val),
    .inst      (inst),
    .inst_rdy  (inst_rdy),
    .trace_val (trace_val),
    .trace     (trace)
  );

  always #4 clk = ~clk;

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic add_entry(input op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input imm_t imm, input bit gap_ok,
                           input int overtakes);
    tbl[n_entries].inst      = '{op, rd, rs1, rs2, imm};
    tbl[n_entries].gap_ok    = gap_ok;
    tbl[n_entries].overtakes = overtakes;
    n_entries++;
  endtask

  // Mixed ALU and multiply ops with RAW and WAW chains
  task automatic load_table();
    add_entry(OP_LI,  3'd1, 3'd0, 3'd0, 16'h0003, 1, -1);
    add_entry(OP_LI,  3'd2, 3'd0, 3'd0, 16'h0005, 1, -1);
    add_entry(OP_MUL, 3'd3, 3'd1, 3'd2, 16'h0000, 1, -1);
    add_entry(OP_ADD, 3'd4, 3'd1, 3'd2, 16'h0000, 0, 2);   // Passes the multiply
    add_entry(OP_XOR, 3'd5, 3'd1, 3'd2, 16'h0000, 1, -1);
    add_entry(OP_ADD, 3'd6, 3'd3, 3'd4, 16'h0000, 1, -1);  // RAW on multiply result
    add_entry(OP_MUL, 3'd7, 3'd6, 3'd6, 16'h0000, 1, -1);
    add_entry(OP_SUB, 3'd1, 3'd5, 3'd2, 16'h0000, 0, 6);
    add_entry(OP_AND, 3'd2, 3'd7, 3'd1, 16'h0000, 1, -1);
    add_entry(OP_LI,  3'd0, 3'd0, 3'd0, 16'h00ab, 1, -1);  // Write to r0 still traces
    add_entry(OP_ADD, 3'd4, 3'd0, 3'd2, 16'h0000, 1, -1);
    add_entry(OP_SLL, 3'd5, 3'd6, 3'd4, 16'h0000, 1, -1);
    add_entry(OP_MUL, 3'd3, 3'd5, 3'd5, 16'h0000, 1, -1);
    add_entry(OP_MUL, 3'd3, 3'd3, 3'd6, 16'h0000, 1, -1);  // WAW and RAW on r3
    add_entry(OP_LI,  3'd6, 3'd0, 3'd0, 16'hffff, 1, -1);
    add_entry(OP_MUL, 3'd7, 3'd6, 3'd6, 16'h0000, 1, -1);
    add_entry(OP_ADD, 3'd1, 3'd1, 3'd6, 16'h0000, 1, -1);
    add_entry(OP_SLL, 3'd2, 3'd6, 3'd6, 16'h0000, 1, -1);
    add_entry(OP_XOR, 3'd4, 3'd7, 3'd2, 16'h0000, 1, -1);
    add_entry(OP_SUB, 3'd5, 3'd0, 3'd1, 16'h0000, 1, -1);
    add_entry(OP_MUL, 3'd0, 3'd5, 3'd3, 16'h0000, 1, -1);
    add_entry(OP_ADD, 3'd6, 3'd0, 3'd0, 16'h0000, 1, -1);  // r0 reads zero
    add_entry(OP_MUL, 3'd2, 3'd4, 3'd1, 16'h0000, 1, -1);
    add_entry(OP_AND, 3'd7, 3'd2, 3'd5, 16'h0000, 1, -1);
  endtask

  // In-order reference model
  task automatic compute_expected();
    data_t regs [num_regs];
    data_t a;
    data_t b;
    data_t r;
    for (int i = 0; i < num_regs; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < n_entries; i++) begin
      a = regs[tbl[i].inst.rs1];
      b = (tbl[i].inst.op == OP_LI) ? data_t'(tbl[i].inst.imm) : regs[tbl[i].inst.rs2];
      case (tbl[i].inst.op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_XOR:  r = a ^ b;
        OP_SLL:  r = a << b[4:0];
        OP_LI:   r = b;
        OP_MUL:  r = a * b;  // Low 32 bits
        default: r = '0;
      endcase
      tbl[i].exp_waddr = tbl[i].inst.rd;
      tbl[i].exp_wdata = r;
      if (tbl[i].inst.rd != '0) begin
        regs[tbl[i].inst.rd] = r;
      end
    end
  endtask

  task automatic check_trace(input result_t t);
    int idx;
    idx = int'(t.seq);
    assert (idx < n_entries)
      else stop_run($sformatf("Error at time %0t: seq %0d beyond table", $time, idx));
    assert (!seen[idx])
      else stop_run($sformatf("Error at time %0t: seq %0d traced twice", $time, idx));
    assert (t.waddr == tbl[idx].exp_waddr && t.wdata == tbl[idx].exp_wdata)
      else stop_run($sformatf("Error at time %0t: seq %0d wrote r%0d = %h, expected r%0d = %h",
                              $time, idx, t.waddr, t.wdata, tbl[idx].exp_waddr,
                              tbl[idx].exp_wdata));
    if (tbl[idx].overtakes >= 0) begin
      assert (!seen[tbl[idx].overtakes])
        else stop_run($sformatf("Error at time %0t: seq %0d traced after seq %0d",
                                $time, idx, tbl[idx].overtakes));
    end
    seen[idx] = 1'b1;
    trace_count++;
  endtask

  //------------------------------------------------------------
  // Trace monitor and stimulus
  //------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset && trace_val) begin
      check_trace(trace);
    end
    assert (blimp_core_inst.blimp_core_assert_inst.fail_count == 0)
      else stop_run("A bound assertion on the core internals failed");
  end

  initial begin
    int wait_cycles;
    clk         = 1'b0;
    reset       = 1'b1;
    inst_val    = 1'b0;
    inst        = '0;
    trace_count = 0;
    n_entries   = 0;
    lcg_state   = 32'h4c76;
    for (int i = 0; i < tbl_size; i++) begin
      seen[i] = 1'b0;
    end
    load_table();
    compute_expected();

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < n_entries; i++) begin
      lcg_state = lcg_next(lcg_state);
      if (tbl[i].gap_ok && lcg_state[31:30] == 2'b00) begin
        inst_val = 1'b0;  // Idle cycle
        @(negedge clk);
      end
      inst_val    = 1'b1;
      inst        = tbl[i].inst;
      #1;
      wait_cycles = 0;
      while (!inst_rdy) begin
        @(negedge clk);
        #1;
        wait_cycles++;
        if (wait_cycles > wait_limit) begin
          stop_run($sformatf("Timed out: table entry %0d was never accepted", i));
        end
      end
      @(negedge clk);  // Accepted on the rising edge in between
    end
    inst_val = 1'b0;

    wait_cycles = 0;
    while (trace_count < n_entries) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > wait_limit) begin
        stop_run("Timed out waiting for all trace records");
      end
    end
    repeat (10) @(negedge clk);  // Stray traces would show up here
    #1;

    if (trace_count == n_entries) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_run($sformatf("Error at time %0t: %0d trace records, expected %0d",
                         $time, trace_count, n_entries));
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
common/blimp_pkg.sv
hw/decode_issue/decode_issue_unit.sv
hw/execute/alu_unit.sv
hw/execute/ex_queue.sv
hw/execute/pipelined_multiplier.sv
hw/writeback/writeback_unit.sv
hw/blimp_core.sv
test/blimp_core_assert.sv
test/blimp_core_tb.sv
